/* averagePooling.f */
+incdir+hdl
hdl/poolingPkg.sv
hdl/pixelCapture.sv
hdl/frameLatch.sv
hdl/poolSequencer.sv
hdl/blockAverage.sv
hdl/averagePooling.sv
verification/averagePoolingTb.sv

/* Makefile */
TOOL       = verilator
FLAGS      = --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = averagePoolingTb
FILELIST   = averagePooling.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_TEXT  = === PASS ===

SOURCES = $(wildcard hdl/*.sv hdl/*.svh verification/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/averagePoolingTb.sv */
`include "pooling_consts.svh"

module averagePoolingTb;

	timeunit 1ns;
	timeprecision 100ps;

	import poolingPkg::*;

	localparam int finishLimit   = 400;
	localparam int observeCycles = 20;
	localparam int hotBlock      = 77;
	localparam int notYet        = 1000000000;

	typedef logic [`POOL_PIXEL_BITS+1:0] sumT;

	logic  Clock = 1'b0;
	logic  rst;
	pixelT pixelIn;
	logic  pixelValid;
	pixelT pooledPixel;
	logic  pooledValid;
	logic  finish;

	integer seed;
	pixelT  frameModel [`POOL_PIXELS];
	int     cycleCount     = 0;
	int     acceptEdge     = notYet;
	int     outCount       = 0;
	int     pooledSeen     = 0;
	int     valueErrors    = 0;
	int     protocolErrors = 0;
	int     timeoutErrors  = 0;
	logic   prevValid      = 1'b0;
	logic   rstSampled     = 1'b0;
	bit     timedOut;

	averagePooling u_averagePooling
	(
		.Clock       (Clock),
		.rst         (rst),
		.pixelIn     (pixelIn),
		.pixelValid  (pixelValid),
		.pooledPixel (pooledPixel),
		.pooledValid (pooledValid),
		.finish      (finish)
	);

	always #2 Clock = ~Clock;

	always @(posedge Clock)
	begin
		cycleCount <= cycleCount + 1;
		rstSampled <= rst;
	end

	// mean of one 2x2 block, four pixels summed without wrap
	function automatic pixelT expectedMean(input int blockIndex);
		int  base;
		sumT sum;
		base = (blockIndex / `POOL_OUT_WIDTH) * 2 * `POOL_IMG_WIDTH
			+ (blockIndex % `POOL_OUT_WIDTH) * 2;
		sum = sumT'(frameModel[base]) + sumT'(frameModel[base + 1])
			+ sumT'(frameModel[base + `POOL_IMG_WIDTH])
			+ sumT'(frameModel[base + `POOL_IMG_WIDTH + 1]);
		return pixelT'(sum >> 2);
	endfunction

	//////////////////////////////
	// output checks
	//////////////////////////////

	// emission runs without gaps and hands over to finish
	assert property (@(posedge Clock) disable iff (rst) pooledValid |=> (pooledValid || finish))
	else
	begin
		protocolErrors++;
		$display("pooledValid dropped without finish at cycle %0d", cycleCount);
	end

	// finish is sticky
	assert property (@(posedge Clock) disable iff (rst) finish |=> finish)
	else
	begin
		protocolErrors++;
		$display("finish fell without reset at cycle %0d", cycleCount);
	end

	always @(negedge Clock)
	begin
		if (rstSampled)
		begin
			outCount  = 0;
			prevValid = 1'b0;
			assert (!pooledValid && !finish)
			else
			begin
				protocolErrors++;
				$display("pooledValid or finish high during reset at cycle %0d", cycleCount);
			end
		end
		else if (cycleCount < acceptEdge + 2)
		begin
			assert (!pooledValid && !finish)
			else
			begin
				protocolErrors++;
				$display("output active before the frame was complete, cycle %0d", cycleCount);
			end
		end
		else
		begin
			if (pooledValid)
			begin
				assert (outCount < `POOL_BLOCKS)
				else
				begin
					protocolErrors++;
					$display("extra pooledValid after all blocks at cycle %0d", cycleCount);
				end
				assert (outCount > 0 || cycleCount == acceptEdge + 2)
				else
				begin
					protocolErrors++;
					$display("first pooled pixel at cycle %0d, expected cycle %0d",
						cycleCount, acceptEdge + 2);
				end
				assert (outCount == 0 || prevValid)
				else
				begin
					protocolErrors++;
					$display("gap in pooledValid before block %0d", outCount);
				end
				assert (!finish)
				else
				begin
					protocolErrors++;
					$display("finish high together with pooledValid at cycle %0d", cycleCount);
				end
				if (outCount < `POOL_BLOCKS)
				begin
					assert (pooledPixel == expectedMean(outCount))
					else
					begin
						valueErrors++;
						$display("MISMATCH pooledPixel block %0d: got %h, expected %h",
							outCount, pooledPixel, expectedMean(outCount));
					end
				end
				outCount++;
				pooledSeen++;
			end
			else if (prevValid)
			begin
				assert (finish)
				else
				begin
					protocolErrors++;
					$display("finish did not rise right after the last pooledValid");
				end
			end
			prevValid = pooledValid;
		end
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////

	task automatic applyReset();
		rst        = 1'b1;
		pixelValid = 1'b0;
		repeat (3) @(posedge Clock);
		@(negedge Clock);
		rst = 1'b0;
	endtask

	// random frame, optionally with one all-ones block
	task automatic buildFrame(input bit withHot);
		int base;
		for (int i = 0; i < `POOL_PIXELS; i++)
		begin
			frameModel[i] = pixelT'($random(seed));
		end
		if (withHot)
		begin
			base = (hotBlock / `POOL_OUT_WIDTH) * 2 * `POOL_IMG_WIDTH
				+ (hotBlock % `POOL_OUT_WIDTH) * 2;
			frameModel[base]                       = 16'hFFFF;
			frameModel[base + 1]                   = 16'hFFFF;
			frameModel[base + `POOL_IMG_WIDTH]     = 16'hFFFF;
			frameModel[base + `POOL_IMG_WIDTH + 1] = 16'hFFFF;
		end
	endtask

	task automatic sendFrame();
		acceptEdge = notYet;
		for (int i = 0; i < `POOL_PIXELS; i++)
		begin
			// occasional idle cycle between pixels
			if (($random(seed) & 3) == 0)
			begin
				@(negedge Clock);
				pixelValid = 1'b0;
				pixelIn    = pixelT'($random(seed));
			end
			@(negedge Clock);
			pixelValid = 1'b1;
			pixelIn    = frameModel[i];
			if (i == `POOL_PIXELS - 1)
			begin
				acceptEdge = cycleCount + 1;
			end
		end
	endtask

	// pixels the DUT must ignore
	task automatic driveExtraPixel();
		pixelValid = 1'($random(seed));
		pixelIn    = pixelT'($random(seed));
	endtask

	task automatic waitForFinish(output bit expired);
		expired = 1'b1;
		for (int i = 0; i < finishLimit; i++)
		begin
			@(negedge Clock);
			driveExtraPixel();
			if (finish)
			begin
				expired = 1'b0;
				break;
			end
		end
		if (expired)
		begin
			timeoutErrors++;
			$display("finish never rose within %0d cycles", finishLimit);
		end
	endtask

	task automatic checkFinishHeld();
		for (int i = 0; i < observeCycles; i++)
		begin
			@(negedge Clock);
			driveExtraPixel();
			assert (finish)
			else
			begin
				protocolErrors++;
				$display("finish low %0d cycles after it rose", i + 1);
			end
		end
		pixelValid = 1'b0;
		assert (outCount == `POOL_BLOCKS)
		else
		begin
			protocolErrors++;
			$display("frame gave %0d pooled pixels instead of %0d", outCount, `POOL_BLOCKS);
		end
	endtask

	task automatic reportAndFinish();
		$display("pooled pixels seen %0d, value errors %0d, protocol errors %0d, timeouts %0d",
			pooledSeen, valueErrors, protocolErrors, timeoutErrors);
		if (valueErrors + protocolErrors + timeoutErrors == 0)
		begin
			$display("=== PASS ===");
		end
		else
		begin
			$display("=== FAIL ===");
		end
		$finish;
	endtask

	initial
	begin
		seed       = 32'he05a;
		rst        = 1'b1;
		pixelIn    = '0;
		pixelValid = 1'b0;
		applyReset();
		buildFrame(1'b1);
		sendFrame();
		waitForFinish(timedOut);
		if (!timedOut)
		begin
			checkFinishHeld();
			// second frame after a fresh reset
			applyReset();
			buildFrame(1'b0);
			sendFrame();
			waitForFinish(timedOut);
			if (!timedOut)
			begin
				checkFinishHeld();
			end
		end
		reportAndFinish();
	end

endmodule

/* hdl/averagePooling.sv */
`include "pooling_consts.svh"

module averagePooling
(
	input  logic              Clock,
	input  logic              rst,
	input  poolingPkg::pixelT pixelIn,
	input  logic              pixelValid,
	output poolingPkg::pixelT pooledPixel,
	output logic              pooledValid,
	output logic              finish
);

	poolingPkg::pixelT    captureFrame [`POOL_PIXELS];
	logic                 frameFull;
	poolingPkg::blockIdxT blockIdx;
	logic                 blockValid;
	poolingPkg::pixelT    topLeft;
	poolingPkg::pixelT    topRight;
	poolingPkg::pixelT    bottomLeft;
	poolingPkg::pixelT    bottomRight;

	pixelCapture u_pixelCapture
	(
		.Clock        (Clock),
		.rst          (rst),
		.pixelIn      (pixelIn),
		.pixelValid   (pixelValid),
		.captureFrame (captureFrame),
		.frameFull    (frameFull)
	);

	frameLatch u_frameLatch
	(
		.Clock        (Clock),
		.rst          (rst),
		.captureFrame (captureFrame),
		.frameFull    (frameFull),
		.blockIdx     (blockIdx),
		.topLeft      (topLeft),
		.topRight     (topRight),
		.bottomLeft   (bottomLeft),
		.bottomRight  (bottomRight)
	);

	poolSequencer u_poolSequencer
	(
		.Clock      (Clock),
		.rst        (rst),
		.frameFull  (frameFull),
		.blockIdx   (blockIdx),
		.blockValid (blockValid),
		.finish     (finish)
	);

	blockAverage u_blockAverage
	(
		.Clock       (Clock),
		.rst         (rst),
		.topLeft     (topLeft),
		.topRight    (topRight),
		.bottomLeft  (bottomLeft),
		.bottomRight (bottomRight),
		.blockValid  (blockValid),
		.pooledPixel (pooledPixel),
		.pooledValid (pooledValid)
	);

endmodule

/* hdl/blockAverage.sv */
module blockAverage
(
	input  logic              Clock,
	input  logic              rst,
	input  poolingPkg::pixelT topLeft,
	input  poolingPkg::pixelT topRight,
	input  poolingPkg::pixelT bottomLeft,
	input  poolingPkg::pixelT bottomRight,
	input  logic              blockValid,
	output poolingPkg::pixelT pooledPixel,
	output logic              pooledValid
);

	import poolingPkg::*;

	pixelSumT blockSum;
	pixelT    blockMean;

	// full-width sum, cannot wrap
	always_comb
	begin
		blockSum = pixelSumT'(topLeft) + pixelSumT'(topRight)
			+ pixelSumT'(bottomLeft) + pixelSumT'(bottomRight);
	end

	// divide by four, truncated
	assign blockMean = blockSum[$bits(pixelSumT)-1:2];

	//////////////////////////////
	// output register
	//////////////////////////////

	always_ff @(posedge Clock)
	begin
		if (rst)
		begin
			pooledPixel <= '0;
			pooledValid <= 1'b0;
		end
		else
		begin
			pooledValid <= blockValid;
			if (blockValid)
			begin
				pooledPixel <= blockMean;
			end
		end
	end

endmodule

/* hdl/poolSequencer.sv */
`include "pooling_consts.svh"

module poolSequencer
(
	input  logic                 Clock,
	input  logic                 rst,
	input  logic                 frameFull,
	output poolingPkg::blockIdxT blockIdx,
	output logic                 blockValid,
	output logic                 finish
);

	import poolingPkg::*;

	localparam blockIdxT lastBlock = blockIdxT'(`POOL_BLOCKS - 1);

	seqStateT state;
	seqStateT nextState;
	logic     lastIdx;

	assign lastIdx = (blockIdx == lastBlock);

	//////////////////////////////
	// next state
	//////////////////////////////

	always_comb
	begin
		nextState = state;
		case (state)
			seqIdle:
			begin
				if (frameFull)
				begin
					nextState = seqEmit;
				end
			end
			seqEmit:
			begin
				if (lastIdx)
				begin
					nextState = seqDrain;
				end
			end
			// averaging stage still holds the last block
			seqDrain:
			begin
				nextState = seqDone;
			end
			default:
			begin
				nextState = seqDone;
			end
		endcase
	end

	//////////////////////////////
	// state and block index
	//////////////////////////////

	always_ff @(posedge Clock)
	begin
		if (rst)
		begin
			state    <= seqIdle;
			blockIdx <= '0;
		end
		else
		begin
			state <= nextState;
			if (state == seqEmit && !lastIdx)
			begin
				blockIdx <= blockIdx + 1'b1;
			end
		end
	end

	// decoded levels
	assign blockValid = (state == seqEmit);
	assign finish     = (state == seqDone);

endmodule

/* hdl/frameLatch.sv */
`include "pooling_consts.svh"

module frameLatch
(
	input  logic                 Clock,
	input  logic                 rst,
	input  poolingPkg::pixelT    captureFrame [`POOL_PIXELS],
	input  logic                 frameFull,
	input  poolingPkg::blockIdxT blockIdx,
	output poolingPkg::pixelT    topLeft,
	output poolingPkg::pixelT    topRight,
	output poolingPkg::pixelT    bottomLeft,
	output poolingPkg::pixelT    bottomRight
);

	import poolingPkg::*;

	// one image row and two image rows in pixels
	localparam pixelAddrT rowStride   = pixelAddrT'(`POOL_IMG_WIDTH);
	localparam pixelAddrT blockStride = pixelAddrT'(2 * `POOL_IMG_WIDTH);

	pixelT     latchFrame [`POOL_PIXELS];
	blockIdxT  blockRow;
	blockIdxT  blockCol;
	pixelAddrT baseAddr;
	pixelAddrT rightAddr;
	pixelAddrT belowAddr;
	pixelAddrT diagAddr;

	//////////////////////////////
	// frame copy
	//////////////////////////////

	// a reset on the same edge cancels the copy
	always_ff @(posedge Clock)
	begin
		if (frameFull && !rst)
		begin
			latchFrame <= captureFrame;
		end
	end

	//////////////////////////////
	// block addressing
	//////////////////////////////

	// row and column in the pooled grid
	always_comb
	begin
		blockRow = blockIdxT'(blockIdx / `POOL_OUT_WIDTH);
		blockCol = blockIdxT'(blockIdx % `POOL_OUT_WIDTH);
	end

	// top-left corner of the 2x2 block
	always_comb
	begin
		baseAddr  = pixelAddrT'(blockRow * blockStride + blockCol * 2);
		rightAddr = baseAddr + 1'b1;
		belowAddr = baseAddr + rowStride;
		diagAddr  = belowAddr + 1'b1;
	end

	// zero-latency read of the four pixels
	always_comb
	begin
		topLeft     = latchFrame[baseAddr];
		topRight    = latchFrame[rightAddr];
		bottomLeft  = latchFrame[belowAddr];
		bottomRight = latchFrame[diagAddr];
	end

endmodule

/* hdl/pixelCapture.sv */
`include "pooling_consts.svh"

module pixelCapture
(
	input  logic               Clock,
	input  logic               rst,
	input  poolingPkg::pixelT  pixelIn,
	input  logic               pixelValid,
	output poolingPkg::pixelT  captureFrame [`POOL_PIXELS],
	output logic               frameFull
);

	import poolingPkg::*;

	// address of the final pixel of a frame
	localparam pixelAddrT lastAddr = pixelAddrT'(`POOL_PIXELS - 1);

	// counter value once the frame is complete
	localparam pixelAddrT fullAddr = pixelAddrT'(`POOL_PIXELS);

	pixelAddrT writeAddr;
	logic      frameDone;
	logic      acceptPixel;

	// saturated counter blocks any further pixels
	assign frameDone   = (writeAddr == fullAddr);
	assign acceptPixel = pixelValid && !frameDone;

	//////////////////////////////
	// write counter
	//////////////////////////////

	always_ff @(posedge Clock)
	begin
		if (rst)
		begin
			writeAddr <= '0;
		end
		else if (acceptPixel)
		begin
			writeAddr <= writeAddr + 1'b1;
		end
	end

	// single pulse after the last pixel
	always_ff @(posedge Clock)
	begin
		if (rst)
		begin
			frameFull <= 1'b0;
		end
		else
		begin
			frameFull <= acceptPixel && (writeAddr == lastAddr);
		end
	end

	//////////////////////////////
	// capture buffer
	//////////////////////////////

	always_ff @(posedge Clock)
	begin
		if (acceptPixel && !rst)
		begin
			captureFrame[writeAddr] <= pixelIn;
		end
	end

endmodule

/* hdl/poolingPkg.sv */
`include "pooling_consts.svh"

package poolingPkg;

	// one input or output pixel
	typedef logic [`POOL_PIXEL_BITS-1:0] pixelT;

	// raster address inside one frame
	typedef logic [$clog2(`POOL_PIXELS)-1:0] pixelAddrT;

	// pooled pixel index
	typedef logic [$clog2(`POOL_BLOCKS)-1:0] blockIdxT;

	// four pixels added, two carry bits
	typedef logic [`POOL_PIXEL_BITS+1:0] pixelSumT;

	// output sequencer
	typedef enum logic [1:0]
	{
		seqIdle  = 2'd0,
		seqEmit  = 2'd1,
		seqDrain = 2'd2,
		seqDone  = 2'd3
	} seqStateT;

endpackage

/* hdl/pooling_consts.svh */
`ifndef POOLING_CONSTS_SVH
`define POOLING_CONSTS_SVH

//////////////////////////////
// image geometry
//////////////////////////////

`define POOL_PIXEL_BITS 16
`define POOL_IMG_WIDTH  24
`define POOL_IMG_HEIGHT 24

// input frame size
`define POOL_PIXELS     576

// 2x2 pooled output
`define POOL_OUT_WIDTH  12
`define POOL_BLOCKS     144

`endif
